//--- memgame_params.svh
`ifndef MEMGAME_PARAMS_SVH
`define MEMGAME_PARAMS_SVH

// Number of face-down slots, eight pairs
`define CARD_COUNT 16

// Card value width, 1 to 16 used, 0 means empty slot
`define CARD_W 5

// Slot index width
`define SLOT_W 4

// LFSR state width
`define RAND_W 16

// Galois tap mask for x^16+x^14+x^13+x^11+1, right-shift form
`define LFSR_TAPS 16'hB400

`endif

//--- memgame_pkg.sv
`include "memgame_params.svh"

package memgame_pkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [`CARD_W-1:0] card_t;
    typedef logic [`SLOT_W-1:0] slot_t;
    typedef logic [`RAND_W-1:0] rand_t;

    // Whole deck, slot 15 in the top bits down to slot 0 in bits [4:0]
    typedef struct packed {
        card_t slot_15;
        card_t slot_14;
        card_t slot_13;
        card_t slot_12;
        card_t slot_11;
        card_t slot_10;
        card_t slot_9;
        card_t slot_8;
        card_t slot_7;
        card_t slot_6;
        card_t slot_5;
        card_t slot_4;
        card_t slot_3;
        card_t slot_2;
        card_t slot_1;
        card_t slot_0;
    } deck_t;

    ////////////////////////////////////////
    // State machines
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        DEAL_IDLE,
        DEAL_DRAW,
        DEAL_SCAN,
        DEAL_PLACE,
        DEAL_DONE
    } deal_state_t;

    typedef enum logic [1:0] {
        JUDGE_WAIT_FIRST,
        JUDGE_WAIT_SECOND,
        JUDGE_DECIDE
    } judge_state_t;

    ////////////////////////////////////////
    // Deck access by slot index
    ////////////////////////////////////////

    // Read one card out of the deck
    function automatic card_t deck_card(deck_t d, slot_t s);
        logic [`CARD_COUNT*`CARD_W-1:0] flat;
        flat = d;
        return flat[s*`CARD_W +: `CARD_W];
    endfunction

    // Copy of the deck with one slot replaced
    function automatic deck_t deck_place(deck_t d, slot_t s, card_t c);
        logic [`CARD_COUNT*`CARD_W-1:0] flat;
        flat = d;
        flat[s*`CARD_W +: `CARD_W] = c;
        return deck_t'(flat);
    endfunction

endpackage

//--- lfsr_random.sv
`include "memgame_params.svh"

module lfsr_random
    import memgame_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  load,
    input  rand_t seed,
    input  logic  step,
    output rand_t value
);

    // Next state of the shift register
    rand_t next_value;
    // Seed after zero lock-up fix
    rand_t safe_seed;

    ////////////////////////////////////////
    // Galois feedback
    ////////////////////////////////////////

    // Shift right, fold taps in when the bit shifted out is set
    assign next_value = value[0] ? ((value >> 1) ^ rand_t'(`LFSR_TAPS)) : (value >> 1);

    // All-zero state would never leave zero
    assign safe_seed = (seed == '0) ? rand_t'(1) : seed;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            value <= rand_t'(1);
        end
        // Load wins over step
        else if (load)
        begin
            value <= safe_seed;
        end
        else if (step)
        begin
            value <= next_value;
        end
    end

endmodule

//--- pos_generator.sv
`include "memgame_params.svh"

module pos_generator
    import memgame_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  rand_t rand_value,
    output logic  rand_step,
    output deck_t deck,
    output logic  deck_valid
);

    ////////////////////////////////////////
    // Dealer registers
    ////////////////////////////////////////

    deal_state_t state_q;
    // Deck being built, filled from slot 0 upward
    deck_t deck_q;
    // Number of cards already placed, also the next free slot
    slot_t placed_q;
    // Slot currently compared against the candidate
    slot_t scan_q;

    // Candidate from low bits of the stepped LFSR
    card_t candidate;
    // Card under the scan pointer
    card_t scan_card;
    // Scan pointer on the last placed card
    logic  scan_last;
    // Placing into the final slot
    logic  place_last;

    ////////////////////////////////////////
    // Combinational helpers
    ////////////////////////////////////////

    // LFSR steps at the end of DRAW, so value is fresh in SCAN and PLACE
    // and stays put until the next DRAW
    assign candidate = card_t'(rand_value[`SLOT_W-1:0]) + card_t'(1);

    assign scan_card = deck_card(deck_q, scan_q);
    assign scan_last = (scan_q == slot_t'(placed_q - 1'b1));
    assign place_last = (placed_q == slot_t'(`CARD_COUNT - 1));

    // One LFSR step per draw
    assign rand_step = (state_q == DEAL_DRAW);

    assign deck = deck_q;
    assign deck_valid = (state_q == DEAL_DONE);

    ////////////////////////////////////////
    // Rejection-sampling FSM
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= DEAL_IDLE;
            deck_q <= '0;
            placed_q <= '0;
            scan_q <= '0;
        end
        // Start from any state restarts the deal with an empty deck
        else if (start)
        begin
            state_q <= DEAL_DRAW;
            deck_q <= '0;
            placed_q <= '0;
            scan_q <= '0;
        end
        else
        begin
            case (state_q)
                DEAL_DRAW:
                begin
                    scan_q <= '0;
                    // Nothing to compare against for the first card
                    if (placed_q == '0)
                    begin
                        state_q <= DEAL_PLACE;
                    end
                    else
                    begin
                        state_q <= DEAL_SCAN;
                    end
                end
                DEAL_SCAN:
                begin
                    // Repeat found, throw it away and draw again
                    if (scan_card == candidate)
                    begin
                        state_q <= DEAL_DRAW;
                    end
                    else if (scan_last)
                    begin
                        state_q <= DEAL_PLACE;
                    end
                    else
                    begin
                        scan_q <= scan_q + 1'b1;
                    end
                end
                DEAL_PLACE:
                begin
                    deck_q <= deck_place(deck_q, placed_q, candidate);
                    if (place_last)
                    begin
                        state_q <= DEAL_DONE;
                    end
                    else
                    begin
                        placed_q <= placed_q + 1'b1;
                        state_q <= DEAL_DRAW;
                    end
                end
                // IDLE waits for start, DONE holds the deck
                default:
                begin
                    state_q <= state_q;
                end
            endcase
        end
    end

endmodule

//--- pair_judge.sv
`include "memgame_params.svh"

module pair_judge
    import memgame_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  deck_t                  deck,
    input  logic                   deck_valid,
    input  logic                   pick,
    input  slot_t                  pick_slot,
    output card_t                  shown,
    output logic                   match,
    output logic                   miss,
    output logic [`CARD_COUNT-1:0] matched_mask,
    output logic                   game_won
);

    judge_state_t state_q;

    // Held picks for the decide cycle
    slot_t first_slot_q;
    card_t first_card_q;
    slot_t second_slot_q;
    card_t second_card_q;

    // Card behind the slot being picked
    card_t pick_card;
    // Pick is legal in either wait state
    logic  pick_ok;
    logic  first_take;
    logic  second_take;
    logic  same_pair;

    ////////////////////////////////////////
    // Pair rule
    ////////////////////////////////////////

    // Cards 2k-1 and 2k share index k-1
    function automatic logic [`CARD_W-2:0] pair_index(card_t c);
        card_t base;
        base = c - card_t'(1);
        return base[`CARD_W-1:1];
    endfunction

    assign pick_card = deck_card(deck, pick_slot);

    // No picks before the deal ends or on cleared slots
    assign pick_ok = pick && deck_valid && !matched_mask[pick_slot];

    assign first_take = pick_ok && (state_q == JUDGE_WAIT_FIRST);
    // Same slot twice does not count as a second pick
    assign second_take = pick_ok && (state_q == JUDGE_WAIT_SECOND)
                         && (pick_slot != first_slot_q);

    assign same_pair = (pair_index(first_card_q) == pair_index(second_card_q));

    // Full mask means all eight pairs found
    assign game_won = &matched_mask;

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= JUDGE_WAIT_FIRST;
            shown <= '0;
            match <= 1'b0;
            miss <= 1'b0;
            matched_mask <= '0;
        end
        else
        begin
            // Result strobes last one cycle
            match <= 1'b0;
            miss <= 1'b0;
            if (start)
            begin
                // New game clears every pair found so far
                state_q <= JUDGE_WAIT_FIRST;
                matched_mask <= '0;
            end
            else
            begin
                case (state_q)
                    JUDGE_WAIT_FIRST:
                    begin
                        if (first_take)
                        begin
                            shown <= pick_card;
                            state_q <= JUDGE_WAIT_SECOND;
                        end
                    end
                    JUDGE_WAIT_SECOND:
                    begin
                        if (second_take)
                        begin
                            shown <= pick_card;
                            state_q <= JUDGE_DECIDE;
                        end
                    end
                    JUDGE_DECIDE:
                    begin
                        // Picks in this cycle are dropped
                        if (same_pair)
                        begin
                            match <= 1'b1;
                            matched_mask[first_slot_q] <= 1'b1;
                            matched_mask[second_slot_q] <= 1'b1;
                        end
                        else
                        begin
                            miss <= 1'b1;
                        end
                        state_q <= JUDGE_WAIT_FIRST;
                    end
                    default:
                    begin
                        state_q <= JUDGE_WAIT_FIRST;
                    end
                endcase
            end
        end
    end

    // Pick payload registers
    always_ff @(posedge clk)
    begin
        if (first_take)
        begin
            first_slot_q <= pick_slot;
            first_card_q <= pick_card;
        end
        if (second_take)
        begin
            second_slot_q <= pick_slot;
            second_card_q <= pick_card;
        end
    end

endmodule

//--- memory_game_top.sv
`include "memgame_params.svh"

module memory_game_top
    import memgame_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  rand_t                  seed,
    input  logic                   pick,
    input  slot_t                  pick_slot,
    output deck_t                  deck,
    output logic                   deck_valid,
    output card_t                  shown,
    output logic                   match,
    output logic                   miss,
    output logic [`CARD_COUNT-1:0] matched_mask,
    output logic                   game_won
);

    // Dealer to LFSR
    logic  rand_step;
    // LFSR to dealer
    rand_t rand_value;

    ////////////////////////////////////////
    // Random source, seeded on start
    ////////////////////////////////////////

    lfsr_random u_lfsr (
        .clk   (clk),
        .rst   (rst),
        .load  (start),
        .seed  (seed),
        .step  (rand_step),
        .value (rand_value)
    );

    // Dealer builds the shuffled deck
    pos_generator u_dealer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rand_value (rand_value),
        .rand_step  (rand_step),
        .deck       (deck),
        .deck_valid (deck_valid)
    );

    // Judge plays against the dealt deck
    pair_judge u_judge (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .deck         (deck),
        .deck_valid   (deck_valid),
        .pick         (pick),
        .pick_slot    (pick_slot),
        .shown        (shown),
        .match        (match),
        .miss         (miss),
        .matched_mask (matched_mask),
        .game_won     (game_won)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 8;

    // Free-running clock, period 20
    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held over the first cycles, released on an edge
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- memory_game_tb.sv
`include "memgame_params.svh"

module memory_game_tb
    import memgame_pkg::*;
();

    ////////////////////////////////////////
    // Run length
    ////////////////////////////////////////

    localparam int GAMES = 5;
    localparam int PAIRS = `CARD_COUNT / 2;
    localparam int DEAL_BOUND = 4000;
    localparam int PICK_BOUND = 400;
    localparam int PICK_CYCLES = 4;
    localparam int CYCLE_LIMIT = GAMES * (DEAL_BOUND + PICK_BOUND * PICK_CYCLES);
    // Picks during dealing stay well short of the fastest possible deal
    localparam int EARLY_PICKS = 20;
    localparam int CHECK_W = `CARD_COUNT * `CARD_W;

    logic clk;
    logic rst;
    logic start;
    rand_t seed;
    logic pick;
    slot_t pick_slot;
    deck_t deck;
    logic deck_valid;
    card_t shown;
    logic match;
    logic miss;
    logic [`CARD_COUNT-1:0] matched_mask;
    logic game_won;

    integer seed_var;
    int cycle_count = 0;

    // Model of the dealt deck and the game
    card_t exp_deck [`CARD_COUNT];
    card_t exp_shown;
    logic [`CARD_COUNT-1:0] exp_mask;
    logic waiting_second;
    slot_t first_slot;
    int match_count;

    tb_clock_gen u_clock (.clk(clk), .rst(rst));

    memory_game_top dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .seed         (seed),
        .pick         (pick),
        .pick_slot    (pick_slot),
        .deck         (deck),
        .deck_valid   (deck_valid),
        .shown        (shown),
        .match        (match),
        .miss         (miss),
        .matched_mask (matched_mask),
        .game_won     (game_won)
    );

    // Hard stop on a hung run
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task check(input string name, input logic [CHECK_W-1:0] exp, input logic [CHECK_W-1:0] act);
        if (exp !== act)
        begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Cards 2k-1 and 2k belong together
    function int pair_of(card_t v);
        return (int'(v) - 1) / 2;
    endfunction

    // Rejection shuffle driven by the same LFSR stream
    task predict_deck(input rand_t gs);
        rand_t r;
        card_t cand;
        int placed;
        logic dup;
        r = (gs == '0) ? 16'h0001 : gs;
        placed = 0;
        while (placed < `CARD_COUNT)
        begin
            // Right-shift Galois step for x^16+x^14+x^13+x^11+1
            r = r[0] ? ((r >> 1) ^ 16'hB400) : (r >> 1);
            cand = card_t'(r[3:0]) + card_t'(1);
            dup = 1'b0;
            for (int i = 0; i < placed; i++)
            begin
                if (exp_deck[i] == cand)
                begin
                    dup = 1'b1;
                end
            end
            if (!dup)
            begin
                exp_deck[placed] = cand;
                placed++;
            end
        end
    endtask

    // Slot holding the other half of a pair
    function slot_t find_partner(slot_t f);
        slot_t p;
        p = f;
        for (int i = 0; i < `CARD_COUNT; i++)
        begin
            if (i != f && pair_of(exp_deck[i]) == pair_of(exp_deck[f]))
            begin
                p = slot_t'(i);
            end
        end
        return p;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task start_game(input rand_t gs);
        logic [CHECK_W-1:0] exp_flat;
        logic [CHECK_W-1:0] act_flat;
        logic [`CARD_COUNT:0] seen;
        predict_deck(gs);
        @(posedge clk);
        start <= 1'b1;
        seed <= gs;
        @(posedge clk);
        start <= 1'b0;
        exp_mask = '0;
        waiting_second = 1'b0;
        match_count = 0;
        // Start wipes deck, mask and win
        @(negedge clk);
        check("deck_valid", 0, deck_valid);
        check("deck", 0, deck);
        check("matched_mask", 0, matched_mask);
        check("game_won", 0, game_won);
        // Picks while dealing must bounce
        repeat (EARLY_PICKS)
        begin
            @(posedge clk);
            pick <= 1'b1;
            pick_slot <= slot_t'($random(seed_var));
            @(negedge clk);
            check("shown", exp_shown, shown);
            check("deck_valid", 0, deck_valid);
        end
        @(posedge clk);
        pick <= 1'b0;
        @(negedge clk);
        check("shown", exp_shown, shown);
        while (!deck_valid)
        begin
            @(negedge clk);
        end
        seen = '0;
        for (int i = 0; i < `CARD_COUNT; i++)
        begin
            exp_flat[i*`CARD_W +: `CARD_W] = exp_deck[i];
        end
        act_flat = deck;
        for (int i = 0; i < `CARD_COUNT; i++)
        begin
            seen[act_flat[i*`CARD_W +: `CARD_W]] = 1'b1;
        end
        // Each of 1..16 present once
        check("deck permutation", {`CARD_COUNT{1'b1}}, seen[`CARD_COUNT:1]);
        check("deck", exp_flat, act_flat);
    endtask

    task do_pick(input slot_t s);
        logic accepted;
        logic second;
        logic is_match;
        logic junk;
        accepted = !exp_mask[s] && (!waiting_second || s != first_slot);
        second = accepted && waiting_second;
        is_match = 1'b0;
        junk = $random(seed_var);
        @(posedge clk);
        pick <= 1'b1;
        pick_slot <= s;
        @(posedge clk);
        // Stray pick landing in the decide cycle
        if (second && junk)
        begin
            pick <= 1'b1;
            pick_slot <= slot_t'($random(seed_var));
        end
        else
        begin
            pick <= 1'b0;
        end
        if (accepted)
        begin
            exp_shown = exp_deck[s];
            if (second)
            begin
                is_match = (pair_of(exp_deck[first_slot]) == pair_of(exp_deck[s]));
                waiting_second = 1'b0;
            end
            else
            begin
                first_slot = s;
                waiting_second = 1'b1;
            end
        end
        @(negedge clk);
        check("shown", exp_shown, shown);
        check("match", 0, match);
        check("miss", 0, miss);
        check("matched_mask", exp_mask, matched_mask);
        check("game_won", match_count == PAIRS, game_won);
        if (second)
        begin
            @(posedge clk);
            pick <= 1'b0;
            if (is_match)
            begin
                exp_mask[first_slot] = 1'b1;
                exp_mask[s] = 1'b1;
                match_count++;
            end
            // Verdict two cycles after the second pick
            @(negedge clk);
            check("match", is_match, match);
            check("miss", !is_match, miss);
            check("matched_mask", exp_mask, matched_mask);
            check("game_won", match_count == PAIRS, game_won);
            check("shown", exp_shown, shown);
        end
    endtask

    // Random picks with half the second picks aimed at the partner
    task play_game;
        slot_t s;
        while (match_count < PAIRS)
        begin
            if (waiting_second && ($random(seed_var) & 1))
            begin
                s = find_partner(first_slot);
            end
            else
            begin
                s = slot_t'($random(seed_var));
            end
            do_pick(s);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        rand_t game_seed;
        seed_var = 84;
        start = 1'b0;
        seed = '0;
        pick = 1'b0;
        pick_slot = '0;
        exp_shown = '0;
        exp_mask = '0;
        waiting_second = 1'b0;
        first_slot = '0;
        match_count = 0;
        @(negedge rst);
        @(negedge clk);
        // Idle outputs out of reset
        check("deck_valid", 0, deck_valid);
        check("match", 0, match);
        check("miss", 0, miss);
        check("game_won", 0, game_won);
        check("matched_mask", 0, matched_mask);
        check("deck", 0, deck);
        for (int g = 0; g < GAMES; g++)
        begin
            // Game 2 runs with the all-zero seed
            game_seed = (g == 2) ? rand_t'(0) : rand_t'($random(seed_var));
            start_game(game_seed);
            play_game();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
memgame_pkg.sv
lfsr_random.sv
pos_generator.sv
pair_judge.sv
memory_game_top.sv
tb_clock_gen.sv
memory_game_tb.sv
